//--- Bender.yml
package:
  name: wallace_mul

sources:
  # Design, in compile order
  - files:
      - verilog/wallace_pkg.sv
      - verilog/pp_gen.sv
      - verilog/csa_level.sv
      - verilog/wallace_tree.sv
      - verilog/final_adder.sv
      - verilog/wallace_mul.sv

  # Testbench
  - target: test
    files:
      - tests/wallace_checker.sv
      - tests/tb_wallace_mul.sv

//--- tests/tb_wallace_mul.sv
module tb_wallace_mul;

	timeunit 1ns;
	timeprecision 1ps;

	logic                  clk;
	logic                  rst_n;
	logic                  in_valid;
	wallace_pkg::operand_t a;
	wallace_pkg::operand_t b;
	wallace_pkg::product_t product;
	logic                  out_valid;

	int          error_count;
	int          check_count;
	int          pending;
	int          sent;
	int          timeouts;
	logic [31:0] lfsr_state;

	wallace_mul DUT (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.a        (a),
		.b        (b),
		.product  (product),
		.out_valid(out_valid)
	);

	wallace_checker u_checker (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.a          (a),
		.b          (b),
		.product    (product),
		.out_valid  (out_valid),
		.error_count(error_count),
		.check_count(check_count),
		.pending    (pending)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Random source
	//////////////////////////////////////////////////////////////////////

	// Taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Drivers
	//////////////////////////////////////////////////////////////////////

	task automatic send(input wallace_pkg::operand_t x, input wallace_pkg::operand_t y);
		@(posedge clk);
		in_valid <= 1'b1;
		a        <= x;
		b        <= y;
		sent++;
	endtask

	// Operands keep moving while the strobe is low
	task automatic idle_cycle();
		logic [31:0] ra;
		logic [31:0] rb;
		rand_bits(32, ra);
		rand_bits(32, rb);
		@(posedge clk);
		in_valid <= 1'b0;
		a        <= ra;
		b        <= rb;
	endtask

	task automatic send_random();
		logic [31:0] x;
		logic [31:0] y;
		rand_bits(32, x);
		rand_bits(32, y);
		send(x, y);
	endtask

	task automatic wait_drain();
		int t;
		idle_cycle();
		t = 0;
		while (pending != 0 && t < 4 * wallace_pkg::LATENCY) begin
			@(negedge clk);
			t++;
		end
		if (pending != 0) begin
			$display("Timeout while draining: %0d results never came out", pending);
			timeouts++;
		end
	endtask

	initial begin
		logic [31:0] gap;
		rst_n      = 1'b0;
		in_valid   = 1'b0;
		a          = '0;
		b          = '0;
		sent       = 0;
		timeouts   = 0;
		lfsr_state = 32'hee59298f;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		// Quiet stretch, any out_valid here is spurious
		repeat (20) idle_cycle();

		// Corner operands
		send(32'h0, 32'h0);
		send(32'hffffffff, 32'h0);
		send(32'h1, 32'h1);
		send(32'hffffffff, 32'hffffffff);
		send(32'h80000000, 32'h80000000);
		send(32'hffffffff, 32'h1);
		send(32'h1, 32'hffffffff);
		wait_drain();

		// Back-to-back burst
		repeat (50) send_random();
		wait_drain();

		// Sparse strobes with random gaps
		repeat (60) begin
			send_random();
			rand_bits(3, gap);
			repeat (gap) idle_cycle();
		end
		wait_drain();

		repeat (5) idle_cycle();
		if (check_count != sent) begin
			$display("Sent %0d operand pairs but only %0d results were checked", sent,
				check_count);
		end
		$display("Sent: %0d, checked: %0d, errors: %0d, timeouts: %0d", sent, check_count,
			error_count, timeouts);
		if (error_count == 0 && timeouts == 0 && check_count == sent) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- tests/wallace_checker.sv
module wallace_checker (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  in_valid,
	input  wallace_pkg::operand_t a,
	input  wallace_pkg::operand_t b,
	input  wallace_pkg::product_t product,
	input  logic                  out_valid,
	output int                    error_count,
	output int                    check_count,
	output int                    pending
);

	timeunit 1ns;
	timeprecision 1ps;

	wallace_pkg::operand_t q_a [$];
	wallace_pkg::operand_t q_b [$];
	int                    q_cycle [$];
	int                    cycle;

	// Last expected result, product keeps it until the next out_valid
	wallace_pkg::product_t held_product;

	// Shift-and-add over every multiplier bit
	function automatic wallace_pkg::product_t ref_product(
		input wallace_pkg::operand_t x,
		input wallace_pkg::operand_t y
	);
		wallace_pkg::product_t acc;
		acc = '0;
		for (int i = 0; i < wallace_pkg::OPERAND_W; i++) begin
			if (y[i]) begin
				acc = acc + (wallace_pkg::product_t'(x) << i);
			end
		end
		return acc;
	endfunction

	initial begin
		error_count  = 0;
		check_count  = 0;
		pending      = 0;
		cycle        = 0;
		held_product = '0;
	end

	//////////////////////////////////////////////////////////////////////
	// Scoreboard
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		wallace_pkg::operand_t ea;
		wallace_pkg::operand_t eb;
		wallace_pkg::product_t exp_p;
		int                    issued;
		if (!rst_n) begin
			// Flops are in reset from the first edge on
			if (cycle > 0 && out_valid !== 1'b0) begin
				$display("out_valid was not low during reset at %0t ns", $time);
				error_count++;
			end
			held_product = '0;
		end else begin
			if ($isunknown(out_valid)) begin
				$display("out_valid was unknown at %0t ns", $time);
				error_count++;
			end else if (out_valid) begin
				if (q_a.size() == 0) begin
					$display("Spurious out_valid at %0t ns with nothing in flight", $time);
					error_count++;
				end else begin
					ea     = q_a.pop_front();
					eb     = q_b.pop_front();
					issued = q_cycle.pop_front();
					exp_p  = ref_product(ea, eb);
					check_count++;
					if (product !== exp_p) begin
						$display("** Error at %0t ns: product expected %h, got %h (a=%h b=%h)",
							$time, exp_p, product, ea, eb);
						error_count++;
					end
					if (cycle - issued != wallace_pkg::LATENCY) begin
						$display("Wrong latency at %0t ns: result came %0d cycles after its %s",
							$time, cycle - issued, "operands");
						error_count++;
					end
					held_product = exp_p;
				end
			end else if (product !== held_product) begin
				$display("** Error at %0t ns: product expected %h, got %h with out_valid low",
					$time, held_product, product);
				error_count++;
			end
			if ($isunknown(in_valid)) begin
				$display("in_valid was unknown at %0t ns", $time);
				error_count++;
			end else if (in_valid) begin
				q_a.push_back(a);
				q_b.push_back(b);
				q_cycle.push_back(cycle);
			end
		end
		cycle++;
		pending = q_a.size();
	end

endmodule

//--- verilog/csa_level.sv
module csa_level #(
	parameter int LEVEL = 0
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  valid_in,
	input  wallace_pkg::product_t rows_in [wallace_pkg::rows_at_level(LEVEL)],
	output wallace_pkg::product_t rows_out [wallace_pkg::rows_at_level(LEVEL + 1)],
	output logic                  valid_out
);

	localparam int N_IN   = wallace_pkg::rows_at_level(LEVEL);
	localparam int N_OUT  = wallace_pkg::rows_at_level(LEVEL + 1);
	localparam int GROUPS = N_IN / 3;
	localparam int REST   = N_IN % 3;

	wallace_pkg::product_t next_rows [N_OUT];

	//////////////////////////////////////////////////////////////////////
	// 3:2 compression
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int g = 0; g < GROUPS; g++) begin
			// Sum bits stay in place
			next_rows[2*g] = rows_in[3*g] ^ rows_in[3*g+1] ^ rows_in[3*g+2];
			// Majority carries move up one weight
			next_rows[2*g+1] = ((rows_in[3*g] & rows_in[3*g+1]) |
				(rows_in[3*g] & rows_in[3*g+2]) |
				(rows_in[3*g+1] & rows_in[3*g+2])) << 1;
		end
		// Leftover rows go through untouched
		for (int r = 0; r < REST; r++) begin
			next_rows[2*GROUPS+r] = rows_in[3*GROUPS+r];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Level register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_out <= 1'b0;
			for (int i = 0; i < N_OUT; i++) begin
				rows_out[i] <= '0;
			end
		end else begin
			valid_out <= valid_in;
			if (valid_in) begin
				for (int i = 0; i < N_OUT; i++) begin
					rows_out[i] <= next_rows[i];
				end
			end
		end
	end

endmodule

//--- verilog/final_adder.sv
module final_adder (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  tree_valid,
	input  wallace_pkg::product_t sum_row,
	input  wallace_pkg::product_t carry_row,
	output wallace_pkg::product_t product,
	output logic                  out_valid
);

	//////////////////////////////////////////////////////////////////////
	// Kogge-Stone adder, one half of the product wide
	//////////////////////////////////////////////////////////////////////

	// Returns {carry out, sum}
	function automatic logic [wallace_pkg::OPERAND_W:0] ks_add(
		input wallace_pkg::operand_t x,
		input wallace_pkg::operand_t y,
		input logic                  cin
	);
		wallace_pkg::operand_t prop;
		wallace_pkg::operand_t g;
		wallace_pkg::operand_t t;
		int                    d;
		prop = x ^ y;
		t    = prop;
		g    = x & y;
		// Carry-in folded into bit 0
		g[0] = g[0] | (prop[0] & cin);
		for (int lv = 0; lv < $clog2(wallace_pkg::OPERAND_W); lv++) begin
			d = 1 << lv;
			// High bits first so i-d still holds the previous span
			for (int i = wallace_pkg::OPERAND_W - 1; i >= d; i--) begin
				g[i] = g[i] | (t[i] & g[i-d]);
				t[i] = t[i] & t[i-d];
			end
		end
		return {g[wallace_pkg::OPERAND_W-1],
			prop ^ {g[wallace_pkg::OPERAND_W-2:0], cin}};
	endfunction

	wallace_pkg::operand_t lo_sum;
	logic                  lo_cout;
	wallace_pkg::operand_t hi_sum;

	wallace_pkg::operand_t lo_q;
	logic                  lo_cout_q;
	wallace_pkg::operand_t sum_hi_q;
	wallace_pkg::operand_t carry_hi_q;
	logic                  stage1_valid;

	//////////////////////////////////////////////////////////////////////
	// Stage one, low half
	//////////////////////////////////////////////////////////////////////

	assign {lo_cout, lo_sum} = ks_add(sum_row[wallace_pkg::OPERAND_W-1:0],
		carry_row[wallace_pkg::OPERAND_W-1:0], 1'b0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			stage1_valid <= 1'b0;
			lo_q         <= '0;
			lo_cout_q    <= 1'b0;
			sum_hi_q     <= '0;
			carry_hi_q   <= '0;
		end else begin
			stage1_valid <= tree_valid;
			if (tree_valid) begin
				lo_q       <= lo_sum;
				lo_cout_q  <= lo_cout;
				sum_hi_q   <= sum_row[wallace_pkg::PRODUCT_W-1:wallace_pkg::OPERAND_W];
				carry_hi_q <= carry_row[wallace_pkg::PRODUCT_W-1:wallace_pkg::OPERAND_W];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stage two, high half
	//////////////////////////////////////////////////////////////////////

	// Top carry is always zero for a 64-bit product
	assign hi_sum = wallace_pkg::OPERAND_W'(ks_add(sum_hi_q, carry_hi_q, lo_cout_q));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			product   <= '0;
		end else begin
			out_valid <= stage1_valid;
			if (stage1_valid) begin
				product <= {hi_sum, lo_q};
			end
		end
	end

	a_add_fwd: assert property (
		@(posedge clk) disable iff (!rst_n)
		tree_valid |-> ##(wallace_pkg::ADD_STAGES) out_valid
	);

	a_add_back: assert property (
		@(posedge clk) disable iff (!rst_n)
		out_valid |-> $past(tree_valid, wallace_pkg::ADD_STAGES)
	);

endmodule

//--- verilog/pp_gen.sv
module pp_gen (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 in_valid,
	input  wallace_pkg::operand_t a,
	input  wallace_pkg::operand_t b,
	output wallace_pkg::product_t pp_rows [wallace_pkg::NUM_PP],
	output logic                 pp_valid
);

	wallace_pkg::product_t and_rows [wallace_pkg::NUM_PP];

	// Row i is a gated by b[i], placed at weight 2^i
	always_comb begin
		for (int i = 0; i < wallace_pkg::NUM_PP; i++) begin
			and_rows[i] = wallace_pkg::product_t'(a & {wallace_pkg::OPERAND_W{b[i]}}) << i;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pp_valid <= 1'b0;
			for (int i = 0; i < wallace_pkg::NUM_PP; i++) begin
				pp_rows[i] <= '0;
			end
		end else begin
			pp_valid <= in_valid;
			// Rows hold between strobes
			if (in_valid) begin
				for (int i = 0; i < wallace_pkg::NUM_PP; i++) begin
					pp_rows[i] <= and_rows[i];
				end
			end
		end
	end

	// An unknown strobe would poison the whole pipeline
	a_in_valid_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		!$isunknown(in_valid)
	);

endmodule

//--- verilog/wallace_mul.sv
module wallace_mul (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  in_valid,
	input  wallace_pkg::operand_t a,
	input  wallace_pkg::operand_t b,
	output wallace_pkg::product_t product,
	output logic                  out_valid
);

	wallace_pkg::product_t pp_rows [wallace_pkg::NUM_PP];
	logic                  pp_valid;
	wallace_pkg::product_t sum_row;
	wallace_pkg::product_t carry_row;
	logic                  tree_valid;

	pp_gen u_pp_gen (
		.clk     (clk),
		.rst_n   (rst_n),
		.in_valid(in_valid),
		.a       (a),
		.b       (b),
		.pp_rows (pp_rows),
		.pp_valid(pp_valid)
	);

	wallace_tree u_tree (
		.clk       (clk),
		.rst_n     (rst_n),
		.pp_valid  (pp_valid),
		.pp_rows   (pp_rows),
		.sum_row   (sum_row),
		.carry_row (carry_row),
		.tree_valid(tree_valid)
	);

	final_adder u_adder (
		.clk       (clk),
		.rst_n     (rst_n),
		.tree_valid(tree_valid),
		.sum_row   (sum_row),
		.carry_row (carry_row),
		.product   (product),
		.out_valid (out_valid)
	);

endmodule

//--- verilog/wallace_pkg.sv
package wallace_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths and pipeline depth
	//////////////////////////////////////////////////////////////////////

	localparam int OPERAND_W = 32;
	localparam int PRODUCT_W = 2 * OPERAND_W;

	// One AND row per multiplier bit
	localparam int NUM_PP = OPERAND_W;

	// 32 rows need eight 3:2 levels to reach two
	localparam int CSA_LEVELS = 8;
	localparam int ADD_STAGES = 2;

	// Operand register, tree levels, split adder
	localparam int LATENCY = 1 + CSA_LEVELS + ADD_STAGES;

	typedef logic [OPERAND_W-1:0] operand_t;

	// Every row in the tree is full product width
	typedef logic [PRODUCT_W-1:0] product_t;

	//////////////////////////////////////////////////////////////////////
	// Tree shape
	//////////////////////////////////////////////////////////////////////

	// Rows entering a level: 32 22 15 10 7 5 4 3 then 2
	function automatic int rows_at_level(input int level);
		int rows;
		rows = NUM_PP;
		for (int l = 0; l < level; l++) begin
			// Each full group of three leaves two, leftovers pass
			rows = (rows / 3) * 2 + rows % 3;
		end
		return rows;
	endfunction

endpackage

//--- verilog/wallace_tree.sv
module wallace_tree (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  pp_valid,
	input  wallace_pkg::product_t pp_rows [wallace_pkg::NUM_PP],
	output wallace_pkg::product_t sum_row,
	output wallace_pkg::product_t carry_row,
	output logic                  tree_valid
);

	// One registered level per iteration, each feeding the next
	for (genvar l = 0; l < wallace_pkg::CSA_LEVELS; l++) begin : g_lvl
		localparam int N_IN  = wallace_pkg::rows_at_level(l);
		localparam int N_OUT = wallace_pkg::rows_at_level(l + 1);

		wallace_pkg::product_t lvl_rows_in [N_IN];
		wallace_pkg::product_t lvl_rows [N_OUT];
		logic                  lvl_valid_in;
		logic                  lvl_valid;

		if (l == 0) begin : g_head
			assign lvl_rows_in  = pp_rows;
			assign lvl_valid_in = pp_valid;
		end else begin : g_chain
			assign lvl_rows_in  = g_lvl[l-1].lvl_rows;
			assign lvl_valid_in = g_lvl[l-1].lvl_valid;
		end

		csa_level #(
			.LEVEL(l)
		) u_level (
			.clk      (clk),
			.rst_n    (rst_n),
			.valid_in (lvl_valid_in),
			.rows_in  (lvl_rows_in),
			.rows_out (lvl_rows),
			.valid_out(lvl_valid)
		);
	end

	// Last level leaves exactly a sum row and a carry row
	assign sum_row    = g_lvl[wallace_pkg::CSA_LEVELS-1].lvl_rows[0];
	assign carry_row  = g_lvl[wallace_pkg::CSA_LEVELS-1].lvl_rows[1];
	assign tree_valid = g_lvl[wallace_pkg::CSA_LEVELS-1].lvl_valid;

	// Valid walks the chain one level per cycle, no drops or extras
	a_tree_fwd: assert property (
		@(posedge clk) disable iff (!rst_n)
		pp_valid |-> ##(wallace_pkg::CSA_LEVELS) tree_valid
	);

	a_tree_back: assert property (
		@(posedge clk) disable iff (!rst_n)
		tree_valid |-> $past(pp_valid, wallace_pkg::CSA_LEVELS)
	);

endmodule

//--- wallace_mul.f
verilog/wallace_pkg.sv
verilog/pp_gen.sv
verilog/csa_level.sv
verilog/wallace_tree.sv
verilog/final_adder.sv
verilog/wallace_mul.sv
tests/wallace_checker.sv
tests/tb_wallace_mul.sv
